/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_axi_mem
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* rtl/axi_mem_top.sv */
`timescale 1ns/1ps

module axi_mem_top
  import axi_pkg::*;
  import mem_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  input  logic              i_s_axi_awvalid,
  input  id_t               i_s_axi_awid,
  input  addr_t             i_s_axi_awaddr,
  input  size_t             i_s_axi_awsize,
  input  burst_t            i_s_axi_awburst,
  output logic              o_s_axi_awready,

  input  logic              i_s_axi_wvalid,
  input  logic [data_w-1:0] i_s_axi_wdata,
  input  logic [lanes-1:0]  i_s_axi_wstrb,
  input  logic              i_s_axi_wlast,
  output logic              o_s_axi_wready,

  output logic              o_s_axi_bvalid,
  output id_t               o_s_axi_bid,
  output resp_t             o_s_axi_bresp,
  input  logic              i_s_axi_bready,

  input  logic              i_s_axi_arvalid,
  input  id_t               i_s_axi_arid,
  input  addr_t             i_s_axi_araddr,
  input  len_t              i_s_axi_arlen,
  input  size_t             i_s_axi_arsize,
  input  burst_t            i_s_axi_arburst,
  output logic              o_s_axi_arready,

  output logic              o_s_axi_rvalid,
  output id_t               o_s_axi_rid,
  output logic [data_w-1:0] o_s_axi_rdata,
  output resp_t             o_s_axi_rresp,
  output logic              o_s_axi_rlast,
  input  logic              i_s_axi_rready
);

  aw_req_t aw_in;
  aw_req_t aw_req;
  logic    aw_valid;
  logic    aw_ready;

  w_beat_t w_in;
  w_beat_t w_beat;
  logic    w_valid;
  logic    w_ready;

  logic              wr_en;
  word_addr_t        wr_addr;
  logic [data_w-1:0] wr_data;
  logic [lanes-1:0]  wr_strb;

  logic              rd_en;
  word_addr_t        rd_addr;
  logic [data_w-1:0] lane_data;

  assign aw_in = '{id: i_s_axi_awid, addr: i_s_axi_awaddr,
                   size: i_s_axi_awsize, burst: i_s_axi_awburst};
  assign w_in = '{data: i_s_axi_wdata, strb: i_s_axi_wstrb, last: i_s_axi_wlast};

  // Only OKAY is ever returned
  assign o_s_axi_bresp = resp_okay;
  assign o_s_axi_rresp = resp_okay;

  // ------------------------------
  // Write path
  // ------------------------------
  axi_skid_buffer #(.payload_t(aw_req_t)) u_aw_skid (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_s_axi_awvalid),
    .i_data  (aw_in),
    .o_ready (o_s_axi_awready),
    .o_valid (aw_valid),
    .o_data  (aw_req),
    .i_ready (aw_ready)
  );

  axi_skid_buffer #(.payload_t(w_beat_t)) u_w_skid (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_s_axi_wvalid),
    .i_data  (w_in),
    .o_ready (o_s_axi_wready),
    .o_valid (w_valid),
    .o_data  (w_beat),
    .i_ready (w_ready)
  );

  axi_write_engine u_write_engine (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_aw_valid (aw_valid),
    .i_aw_req   (aw_req),
    .o_aw_ready (aw_ready),
    .i_w_valid  (w_valid),
    .i_w_beat   (w_beat),
    .o_w_ready  (w_ready),
    .o_bvalid   (o_s_axi_bvalid),
    .o_bid      (o_s_axi_bid),
    .i_bready   (i_s_axi_bready),
    .o_wr_en    (wr_en),
    .o_wr_addr  (wr_addr),
    .o_wr_data  (wr_data),
    .o_wr_strb  (wr_strb)
  );

  // ------------------------------
  // Read path
  // ------------------------------
  axi_read_engine u_read_engine (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_arvalid   (i_s_axi_arvalid),
    .i_arid      (i_s_axi_arid),
    .i_araddr    (i_s_axi_araddr),
    .i_arlen     (i_s_axi_arlen),
    .i_arsize    (i_s_axi_arsize),
    .i_arburst   (i_s_axi_arburst),
    .o_arready   (o_s_axi_arready),
    .o_rvalid    (o_s_axi_rvalid),
    .o_rid       (o_s_axi_rid),
    .o_rlast     (o_s_axi_rlast),
    .i_rready    (i_s_axi_rready),
    .o_rd_en     (rd_en),
    .o_rd_addr   (rd_addr),
    .i_lane_data (lane_data),
    .o_rdata     (o_s_axi_rdata)
  );

  // One memory per byte lane
  for (genvar g = 0; g < lanes; g++) begin : g_lane
    mem_byte_lane u_lane (
      .clk       (clk),
      .i_wr_en   (wr_en),
      .i_wr_addr (wr_addr),
      .i_wr_data (wr_data[g*lane_w +: lane_w]),
      .i_wr_strb (wr_strb[g]),
      .i_rd_en   (rd_en),
      .i_rd_addr (rd_addr),
      .o_rd_data (lane_data[g*lane_w +: lane_w])
    );
  end

endmodule

/* rtl/axi_pkg.sv */
package axi_pkg;
  import mem_pkg::*;

  // ------------------------------
  // Field widths
  // ------------------------------
  localparam int id_w = 4;
  localparam int addr_w = word_addr_w + word_lsb;

  typedef logic [id_w-1:0] id_t;
  typedef logic [addr_w-1:0] addr_t;
  typedef logic [7:0] len_t;
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;
  typedef logic [1:0] resp_t;

  // WRAP is stepped like INCR
  localparam burst_t burst_fixed = 2'b00;
  localparam resp_t resp_okay = 2'b00;

  // ------------------------------
  // Write channel payloads
  // ------------------------------
  typedef struct packed {
    id_t id;
    addr_t addr;
    size_t size;
    burst_t burst;
  } aw_req_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [lanes-1:0] strb;
    logic last;
  } w_beat_t;

endpackage

/* rtl/axi_read_engine.sv */
`timescale 1ns/1ps

module axi_read_engine
  import axi_pkg::*;
  import mem_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_arvalid,
  input  id_t               i_arid,
  input  addr_t             i_araddr,
  input  len_t              i_arlen,
  input  size_t             i_arsize,
  input  burst_t            i_arburst,
  output logic              o_arready,
  output logic              o_rvalid,
  output id_t               o_rid,
  output logic              o_rlast,
  input  logic              i_rready,
  output logic              o_rd_en,
  output word_addr_t        o_rd_addr,
  input  logic [data_w-1:0] i_lane_data,
  output logic [data_w-1:0] o_rdata
);

  typedef enum logic {
    st_idle,
    st_burst
  } rd_state_e;

  rd_state_e state;

  id_t    id_q;
  addr_t  addr_q;
  len_t   len_q;
  size_t  size_q;
  burst_t burst_q;

  logic   take_ar;
  logic   launch;
  logic   final_launch;
  id_t    cur_id;
  addr_t  cur_addr;
  len_t   cur_len;
  size_t  cur_size;
  burst_t cur_burst;
  addr_t  next_addr;

  // One burst at a time
  assign o_arready = (state == st_idle);
  assign take_ar = o_arready && i_arvalid;

  // Fresh request feeds the first beat directly
  assign cur_id = take_ar ? i_arid : id_q;
  assign cur_addr = take_ar ? i_araddr : addr_q;
  assign cur_len = take_ar ? i_arlen : len_q;
  assign cur_size = take_ar ? i_arsize : size_q;
  assign cur_burst = take_ar ? i_arburst : burst_q;

  // Launch a beat whenever the R register can take it
  assign launch = (!o_rvalid || i_rready) && (take_ar || state == st_burst);
  assign final_launch = launch && (cur_len == '0);

  assign next_addr = (cur_burst == burst_fixed) ? cur_addr
                                                : cur_addr + (addr_t'(1) << cur_size);

  assign o_rd_en = launch;
  assign o_rd_addr = cur_addr[addr_w-1:word_lsb];

  // Lane registers only update on launch, so they track rvalid
  assign o_rdata = i_lane_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
      o_rvalid <= 1'b0;
    end else begin
      if (final_launch) begin
        state <= st_idle;
      end else if (take_ar) begin
        state <= st_burst;
      end
      if (launch) begin
        o_rvalid <= 1'b1;
      end else if (i_rready) begin
        o_rvalid <= 1'b0;
      end
    end
  end

  // ------------------------------
  // Burst tracking
  // ------------------------------
  always_ff @(posedge clk) begin
    if (take_ar) begin
      id_q <= i_arid;
      size_q <= i_arsize;
      burst_q <= i_arburst;
    end
    if (launch) begin
      addr_q <= next_addr;
      len_q <= cur_len - 8'd1;
      o_rid <= cur_id;
      o_rlast <= (cur_len == '0);
    end else if (take_ar) begin
      addr_q <= i_araddr;
      len_q <= i_arlen;
    end
  end

  // Lane data must hold along with the R registers
  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_rvalid && !i_rready |=>
      o_rvalid && $stable(o_rlast) && $stable(o_rid) && $stable(o_rdata));

endmodule

/* rtl/axi_skid_buffer.sv */
`timescale 1ns/1ps

module axi_skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     i_valid,
  input  payload_t i_data,
  output logic     o_ready,
  output logic     o_valid,
  output payload_t o_data,
  input  logic     i_ready
);

  logic     main_valid;
  logic     skid_valid;
  payload_t main_data;
  payload_t skid_data;
  logic     in_fire;
  logic     main_load;
  logic     skid_load;

  // Upstream ready comes straight from a flop
  assign o_ready = !skid_valid;
  assign o_valid = main_valid;
  assign o_data = main_data;

  assign in_fire = i_valid && o_ready;

  // Main slot refills whenever it is empty or being drained
  assign main_load = !main_valid || i_ready;
  assign skid_load = !main_load && in_fire;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_load) begin
      main_valid <= skid_valid || in_fire;
      skid_valid <= 1'b0;
    end else if (skid_load) begin
      skid_valid <= 1'b1;
    end
  end

  // Skid entry is older, so it goes first
  always_ff @(posedge clk) begin
    if (main_load) begin
      main_data <= skid_valid ? skid_data : i_data;
    end
    if (skid_load) begin
      skid_data <= i_data;
    end
  end

  hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

/* rtl/axi_write_engine.sv */
`timescale 1ns/1ps

module axi_write_engine
  import axi_pkg::*;
  import mem_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_aw_valid,
  input  aw_req_t           i_aw_req,
  output logic              o_aw_ready,
  input  logic              i_w_valid,
  input  w_beat_t           i_w_beat,
  output logic              o_w_ready,
  output logic              o_bvalid,
  output id_t               o_bid,
  input  logic              i_bready,
  output logic              o_wr_en,
  output word_addr_t        o_wr_addr,
  output logic [data_w-1:0] o_wr_data,
  output logic [lanes-1:0]  o_wr_strb
);

  typedef enum logic [1:0] {
    st_idle,
    st_burst,
    st_resp
  } wr_state_e;

  wr_state_e state;
  wr_state_e state_next;

  // Burst parameters with the address stepped per beat
  aw_req_t burst_q;
  aw_req_t cur;

  logic  b_free;
  logic  take_aw;
  logic  w_fire;
  logic  last_beat;
  addr_t next_addr;

  assign b_free = !o_bvalid || i_bready;

  // New AW only once any earlier response is on its way out
  assign o_aw_ready = (state != st_burst) && b_free;
  assign take_aw = o_aw_ready && i_aw_valid;

  // First beat may land in the same cycle as its AW
  assign cur = take_aw ? i_aw_req : burst_q;
  assign o_w_ready = b_free && (take_aw || state == st_burst);
  assign w_fire = i_w_valid && o_w_ready;
  assign last_beat = w_fire && i_w_beat.last;

  assign next_addr = (cur.burst == burst_fixed) ? cur.addr
                                                : cur.addr + (addr_t'(1) << cur.size);

  // ------------------------------
  // Memory write port
  // ------------------------------
  assign o_wr_en = w_fire;
  assign o_wr_addr = cur.addr[addr_w-1:word_lsb];
  assign o_wr_data = i_w_beat.data;
  assign o_wr_strb = i_w_beat.strb;

  always_comb begin
    state_next = state;
    if (take_aw) begin
      state_next = st_burst;
    end else if (state == st_resp && b_free) begin
      state_next = st_idle;
    end
    if (last_beat) begin
      state_next = st_resp;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
      o_bvalid <= 1'b0;
    end else begin
      state <= state_next;
      if (last_beat) begin
        o_bvalid <= 1'b1;
      end else if (i_bready) begin
        o_bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_aw) begin
      burst_q <= i_aw_req;
    end
    if (w_fire) begin
      burst_q.addr <= next_addr;
    end
    if (last_beat) begin
      o_bid <= cur.id;
    end
  end

  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bid));

endmodule

/* rtl/mem_byte_lane.sv */
`timescale 1ns/1ps

module mem_byte_lane
  import mem_pkg::*;
(
  input  logic              clk,
  input  logic              i_wr_en,
  input  word_addr_t        i_wr_addr,
  input  logic [lane_w-1:0] i_wr_data,
  input  logic              i_wr_strb,
  input  logic              i_rd_en,
  input  word_addr_t        i_rd_addr,
  output logic [lane_w-1:0] o_rd_data
);

  logic [lane_w-1:0] mem [depth];

  // Byte only changes when its strobe is set
  always_ff @(posedge clk) begin
    if (i_wr_en && i_wr_strb) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // Output holds between read enables
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

/* rtl/mem_pkg.sv */
package mem_pkg;

  // ------------------------------
  // Word and lane geometry
  // ------------------------------
  localparam int data_w = 32;
  localparam int lanes = data_w / 8;
  localparam int lane_w = data_w / lanes;

  // Byte address bits below the word index
  localparam int word_lsb = $clog2(lanes);

  localparam int word_addr_w = 8;
  localparam int depth = 1 << word_addr_w;

  typedef logic [word_addr_w-1:0] word_addr_t;

endpackage

/* sim.f */
rtl/mem_pkg.sv
rtl/axi_pkg.sv
rtl/axi_skid_buffer.sv
rtl/axi_write_engine.sv
rtl/mem_byte_lane.sv
rtl/axi_read_engine.sv
rtl/axi_mem_top.sv
test/tb_axi_mem.sv

/* test/tb_axi_mem.sv */
`timescale 1ns/1ps

module tb_axi_mem
  import axi_pkg::*;
  import mem_pkg::*;
();

  localparam int     timeout_cycles = 200;
  localparam burst_t burst_incr = 2'b01;
  localparam resp_t  okay_resp = 2'b00;

  logic clk;
  logic rst_n;

  logic              i_s_axi_awvalid;
  id_t               i_s_axi_awid;
  addr_t             i_s_axi_awaddr;
  size_t             i_s_axi_awsize;
  burst_t            i_s_axi_awburst;
  logic              o_s_axi_awready;
  logic              i_s_axi_wvalid;
  logic [data_w-1:0] i_s_axi_wdata;
  logic [lanes-1:0]  i_s_axi_wstrb;
  logic              i_s_axi_wlast;
  logic              o_s_axi_wready;
  logic              o_s_axi_bvalid;
  id_t               o_s_axi_bid;
  resp_t             o_s_axi_bresp;
  logic              i_s_axi_bready;
  logic              i_s_axi_arvalid;
  id_t               i_s_axi_arid;
  addr_t             i_s_axi_araddr;
  len_t              i_s_axi_arlen;
  size_t             i_s_axi_arsize;
  burst_t            i_s_axi_arburst;
  logic              o_s_axi_arready;
  logic              o_s_axi_rvalid;
  id_t               o_s_axi_rid;
  logic [data_w-1:0] o_s_axi_rdata;
  resp_t             o_s_axi_rresp;
  logic              o_s_axi_rlast;
  logic              i_s_axi_rready;

  // Byte-wise reference memory and burst buffers
  logic [lane_w-1:0] ref_mem [1 << addr_w];
  logic [data_w-1:0] wr_data_buf [16];
  logic [lanes-1:0]  wr_strb_buf [16];
  logic [data_w-1:0] exp_words [16];
  int                exp_beats;
  int                rd_count;
  id_t               exp_rid;
  id_t               exp_bid;
  logic              b_pending;
  logic              throttle;
  logic [data_w-1:0] exp_rdata;
  logic              exp_rlast;

  assign exp_rdata = exp_words[rd_count[3:0]];
  assign exp_rlast = (rd_count == exp_beats - 1);

  axi_mem_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Ready throttling for the B and R channels
  initial begin
    i_s_axi_bready = 1'b1;
    i_s_axi_rready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      i_s_axi_bready = !throttle || ($urandom_range(0, 2) != 0);
      i_s_axi_rready = !throttle || ($urandom_range(0, 2) != 0);
    end
  end

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
    abort_run();
  endtask

  task automatic run_error(input string msg);
    $display("Error: %s", msg);
    abort_run();
  endtask

  // ------------------------------
  // Protocol and data checks
  // ------------------------------
  r_data_ok: assert property (@(posedge clk) disable iff (!rst_n)
    o_s_axi_rvalid && i_s_axi_rready |-> o_s_axi_rdata == exp_rdata)
    else value_mismatch("rdata", $sampled(o_s_axi_rdata), $sampled(exp_rdata));

  r_last_ok: assert property (@(posedge clk) disable iff (!rst_n)
    o_s_axi_rvalid && i_s_axi_rready |-> o_s_axi_rlast == exp_rlast)
    else value_mismatch("rlast", 32'($sampled(o_s_axi_rlast)), 32'($sampled(exp_rlast)));

  r_id_ok: assert property (@(posedge clk) disable iff (!rst_n)
    o_s_axi_rvalid |-> o_s_axi_rid == exp_rid)
    else value_mismatch("rid", 32'($sampled(o_s_axi_rid)), 32'($sampled(exp_rid)));

  r_resp_ok: assert property (@(posedge clk) disable iff (!rst_n)
    o_s_axi_rvalid |-> o_s_axi_rresp == okay_resp)
    else value_mismatch("rresp", 32'($sampled(o_s_axi_rresp)), 32'(okay_resp));

  r_count_ok: assert property (@(posedge clk) disable iff (!rst_n)
    o_s_axi_rvalid |-> rd_count < exp_beats)
    else run_error("rvalid raised after the last expected beat");

  r_stable: assert property (@(posedge clk) disable iff (!rst_n)
    o_s_axi_rvalid && !i_s_axi_rready |=> o_s_axi_rvalid && $stable(o_s_axi_rdata)
      && $stable(o_s_axi_rlast) && $stable(o_s_axi_rid))
    else run_error("R channel changed while rready was low");

  b_id_ok: assert property (@(posedge clk) disable iff (!rst_n)
    o_s_axi_bvalid |-> o_s_axi_bid == exp_bid)
    else value_mismatch("bid", 32'($sampled(o_s_axi_bid)), 32'($sampled(exp_bid)));

  b_resp_ok: assert property (@(posedge clk) disable iff (!rst_n)
    o_s_axi_bvalid |-> o_s_axi_bresp == okay_resp)
    else value_mismatch("bresp", 32'($sampled(o_s_axi_bresp)), 32'(okay_resp));

  b_once: assert property (@(posedge clk) disable iff (!rst_n)
    o_s_axi_bvalid |-> b_pending)
    else run_error("bvalid raised with no write burst open");

  b_stable: assert property (@(posedge clk) disable iff (!rst_n)
    o_s_axi_bvalid && !i_s_axi_bready |=> o_s_axi_bvalid && $stable(o_s_axi_bid))
    else run_error("B channel changed while bready was low");

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic fill_beats(input int beats, input logic full);
    for (int k = 0; k < beats; k++) begin
      wr_data_buf[4'(k)] = $urandom;
      wr_strb_buf[4'(k)] = full ? {lanes{1'b1}} : lanes'($urandom);
    end
  endtask

  task automatic write_burst(input addr_t addr, input int beats, input burst_t burst,
                             input id_t id);
    addr_t a;
    int    waited;
    // Only strobed bytes change in the model
    for (int k = 0; k < beats; k++) begin
      a = (burst == burst_fixed) ? addr : addr + addr_t'(4 * k);
      for (int b = 0; b < lanes; b++) begin
        if (wr_strb_buf[4'(k)][b[word_lsb-1:0]]) begin
          ref_mem[a + addr_t'(b)] = lane_w'(wr_data_buf[4'(k)] >> (lane_w * b));
        end
      end
    end
    exp_bid = id;
    b_pending = 1'b1;
    i_s_axi_awvalid = 1'b1;
    i_s_axi_awid = id;
    i_s_axi_awaddr = addr;
    i_s_axi_awsize = 3'd2;
    i_s_axi_awburst = burst;
    waited = 0;
    while (!o_s_axi_awready) begin
      next_cycle();
      waited++;
      if (waited > timeout_cycles) run_error("timeout waiting for awready");
    end
    next_cycle();
    i_s_axi_awvalid = 1'b0;
    for (int k = 0; k < beats; k++) begin
      i_s_axi_wvalid = 1'b1;
      i_s_axi_wdata = wr_data_buf[4'(k)];
      i_s_axi_wstrb = wr_strb_buf[4'(k)];
      i_s_axi_wlast = (k == beats - 1);
      waited = 0;
      while (!o_s_axi_wready) begin
        next_cycle();
        waited++;
        if (waited > timeout_cycles) run_error("timeout waiting for wready");
      end
      next_cycle();
    end
    i_s_axi_wvalid = 1'b0;
    i_s_axi_wlast = 1'b0;
    waited = 0;
    while (!(o_s_axi_bvalid && i_s_axi_bready)) begin
      next_cycle();
      waited++;
      if (waited > timeout_cycles) run_error("timeout waiting for the write response");
    end
    next_cycle();
    b_pending = 1'b0;
  endtask

  task automatic read_burst(input addr_t addr, input int beats, input burst_t burst,
                            input id_t id);
    addr_t a;
    int    waited;
    for (int k = 0; k < beats; k++) begin
      a = (burst == burst_fixed) ? addr : addr + addr_t'(4 * k);
      for (int b = 0; b < lanes; b++) begin
        exp_words[4'(k)][b*lane_w +: lane_w] = ref_mem[a + addr_t'(b)];
      end
    end
    exp_beats = beats;
    exp_rid = id;
    rd_count = 0;
    i_s_axi_arvalid = 1'b1;
    i_s_axi_arid = id;
    i_s_axi_araddr = addr;
    i_s_axi_arlen = len_t'(beats - 1);
    i_s_axi_arsize = 3'd2;
    i_s_axi_arburst = burst;
    waited = 0;
    while (!o_s_axi_arready) begin
      next_cycle();
      waited++;
      if (waited > timeout_cycles) run_error("timeout waiting for arready");
    end
    next_cycle();
    i_s_axi_arvalid = 1'b0;
    // Beat checks run in the assertions at each transfer
    while (rd_count < beats) begin
      waited = 0;
      while (!(o_s_axi_rvalid && i_s_axi_rready)) begin
        next_cycle();
        waited++;
        if (waited > timeout_cycles) run_error("timeout waiting for a read beat");
      end
      next_cycle();
      rd_count++;
    end
  endtask

  task automatic incr_round();
    int    n;
    addr_t a;
    n = 1 + int'($urandom_range(0, 7));
    a = addr_t'(4 * int'($urandom_range(0, 200)));
    fill_beats(n, 1'b1);
    write_burst(a, n, burst_incr, id_t'($urandom));
    read_burst(a, n, burst_incr, id_t'($urandom));
  endtask

  // Full word first so every byte of the fixed address is known
  task automatic fixed_round();
    int    n;
    addr_t a;
    n = 1 + int'($urandom_range(0, 7));
    a = addr_t'(4 * int'($urandom_range(210, 250)));
    fill_beats(1, 1'b1);
    write_burst(a, 1, burst_fixed, id_t'($urandom));
    fill_beats(n, 1'b0);
    write_burst(a, n, burst_fixed, id_t'($urandom));
    read_burst(a, n, burst_fixed, id_t'($urandom));
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    addr_t a;
    void'($urandom(32'hd558));
    rst_n = 1'b0;
    throttle = 1'b0;
    b_pending = 1'b0;
    exp_beats = 0;
    rd_count = 0;
    exp_rid = '0;
    exp_bid = '0;
    i_s_axi_awvalid = 1'b0;
    i_s_axi_awid = '0;
    i_s_axi_awaddr = '0;
    i_s_axi_awsize = '0;
    i_s_axi_awburst = '0;
    i_s_axi_wvalid = 1'b0;
    i_s_axi_wdata = '0;
    i_s_axi_wstrb = '0;
    i_s_axi_wlast = 1'b0;
    i_s_axi_arvalid = 1'b0;
    i_s_axi_arid = '0;
    i_s_axi_araddr = '0;
    i_s_axi_arlen = '0;
    i_s_axi_arsize = '0;
    i_s_axi_arburst = '0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    assert (o_s_axi_awready && o_s_axi_wready && o_s_axi_arready
            && !o_s_axi_bvalid && !o_s_axi_rvalid)
      else run_error("handshake outputs not at their reset values");

    fill_beats(1, 1'b1);
    write_burst(10'h010, 1, burst_incr, 4'h3);
    read_burst(10'h010, 1, burst_incr, 4'h5);

    // Partial strobes over a fully written word
    for (int i = 0; i < 8; i++) begin
      a = 10'h100 + addr_t'(4 * i);
      fill_beats(1, 1'b1);
      write_burst(a, 1, burst_incr, id_t'(i));
      fill_beats(1, 1'b0);
      write_burst(a, 1, burst_incr, id_t'(i + 8));
      read_burst(a, 1, burst_incr, id_t'(i));
    end

    repeat (4) incr_round();
    repeat (3) fixed_round();

    throttle = 1'b1;
    repeat (6) incr_round();
    repeat (4) fixed_round();
    throttle = 1'b0;

    // A few idle cycles catch stray beats or responses
    repeat (4) next_cycle();
    $display("RESULT: PASS");
    $finish;
  end

endmodule
